/* tb.f */
design/sensor_pkg.sv
design/i2c_req_if.sv
design/i2c_read_engine.sv
design/sensor_poll_ctrl.sv
design/lux_convert.sv
design/reading_bank.sv
design/sensor_hub.sv
bench/i2c_sensor_model.sv
bench/sensor_hub_sva.sv
bench/sensor_hub_tb.sv

/* run.sh */
#!/bin/bash
# Build the testbench with Verilator and run it
set -e
set -o pipefail

verilator --binary --assert -j 0 --top-module sensor_hub_tb -f tb.f -o sensor_hub_sim
./obj_dir/sensor_hub_sim | tee sim.log

if grep -q "Test failed" sim.log; then
	echo "Simulation reported a failure, see sim.log"
	exit 1
fi

/* bench/sensor_hub_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module sensor_hub_tb
	import sensor_pkg::*;
();

	localparam int NUM_SWEEPS = 5;
	localparam int SENSOR_CYCLES = 30 * 4 * I2C_QUARTER; // One read with margin
	localparam int TIMEOUT_CYCLES = NUM_SWEEPS * NUM_SENSORS * SENSOR_CYCLES;
	localparam logic [NUM_SENSORS-1:0] REFUSE_EAST_GEO = 8'b0010_1000;

	logic clk;
	logic rst;
	logic sda_line;
	logic scl_line;
	logic scl_drive_low;
	logic sda_drive_low;
	logic model_sda_low;
	logic sweep_done;
	logic signed [7:0] solar_celsius;
	logic signed [7:0] greenhouse_celsius;
	logic signed [7:0] ambient_celsius;
	logic signed [7:0] geothermal_celsius;
	logic [15:0] n_lux;
	logic [15:0] e_lux;
	logic [15:0] s_lux;
	logic [15:0] w_lux;
	logic [15:0] words [NUM_SENSORS];
	logic [NUM_SENSORS-1:0] refuse;
	logic addr_valid;
	logic [7:0] addr_byte;

	logic [31:0] lfsr = 32'h4e1c44f2;
	int errors = 0;
	int sweeps_seen = 0;
	int addr_count = 0; // Address bytes in the current sweep
	sensor_idx_t addr_pos = '0;
	int exp_val [NUM_SENSORS] = '{default: 0}; // Last good reading per sensor
	string sensor_name [NUM_SENSORS] = '{"solar_celsius", "greenhouse_celsius",
		"ambient_celsius", "geothermal_celsius", "n_lux", "e_lux", "s_lux", "w_lux"};

	// Open-drain bus as a wired-AND of both sides
	assign sda_line = !(sda_drive_low || model_sda_low);
	assign scl_line = !scl_drive_low;

	sensor_hub i_sensor_hub (
		.clk(clk),
		.rst(rst),
		.sda_line(sda_line),
		.scl_drive_low(scl_drive_low),
		.sda_drive_low(sda_drive_low),
		.sweep_done(sweep_done),
		.solar_celsius(solar_celsius),
		.greenhouse_celsius(greenhouse_celsius),
		.ambient_celsius(ambient_celsius),
		.geothermal_celsius(geothermal_celsius),
		.n_lux(n_lux),
		.e_lux(e_lux),
		.s_lux(s_lux),
		.w_lux(w_lux)
	);

	i2c_sensor_model i_model (
		.clk(clk),
		.rst(rst),
		.scl(scl_line),
		.sda(sda_line),
		.words(words),
		.refuse(refuse),
		.sda_drive_low(model_sda_low),
		.addr_valid(addr_valid),
		.addr_byte(addr_byte)
	);

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32 22 2 1
	endfunction

	task automatic random_word(output logic [15:0] w);
		for (int b = 0; b < 16; b++)
		begin
			lfsr = lfsr_step(lfsr);
			w = {w[14:0], lfsr[0]};
		end
	endtask

	// Temperature is the signed upper byte and light is fraction << exponent / 100
	function automatic int expected_value(input logic [15:0] w, input int idx);
		longint scaled;
		if (idx < 4)
			return int'($signed(w[15:8]));
		scaled = longint'(w[11:0]) << w[15:12];
		scaled = scaled / 100;
		return scaled > 65535 ? 65535 : int'(scaled);
	endfunction

	function automatic int dut_value(input int idx);
		case (idx)
			0: return int'(solar_celsius);
			1: return int'(greenhouse_celsius);
			2: return int'(ambient_celsius);
			3: return int'(geothermal_celsius);
			4: return int'(n_lux);
			5: return int'(e_lux);
			6: return int'(s_lux);
			default: return int'(w_lux);
		endcase
	endfunction

	task automatic check_reset_state();
		for (int i = 0; i < NUM_SENSORS; i++)
		begin
			assert (dut_value(i) == 0)
			else
			begin
				errors++;
				$display("[ERROR] %0t %s expected 0 got %0d", $time, sensor_name[i], dut_value(i));
			end
		end
		assert (!scl_drive_low && !sda_drive_low)
		else
		begin
			errors++;
			$display("Bus lines are not released after reset");
		end
	endtask

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Address order and per-sweep results
	always @(posedge clk)
	begin
		if (addr_valid)
		begin
			assert (addr_byte == {SENSOR_ADDR[addr_pos], 1'b1})
			else
			begin
				errors++;
				$display("[ERROR] %0t addr_byte expected %02h got %02h", $time,
					{SENSOR_ADDR[addr_pos], 1'b1}, addr_byte);
			end
			addr_pos = addr_pos + 1'b1;
			addr_count++;
		end
		if (sweep_done)
		begin
			sweeps_seen++;
			assert (addr_count == NUM_SENSORS)
			else
			begin
				errors++;
				$display("Sweep %0d carried %0d addresses instead of %0d", sweeps_seen,
					addr_count, NUM_SENSORS);
			end
			addr_count = 0;
			for (int i = 0; i < NUM_SENSORS; i++)
			begin
				if (!refuse[i])
					exp_val[i] = expected_value(words[i], i); // Refused ones keep old value
				assert (dut_value(i) == exp_val[i])
				else
				begin
					errors++;
					$display("[ERROR] %0t %s expected %0d got %0d", $time, sensor_name[i],
						exp_val[i], dut_value(i));
				end
			end
		end
	end

	initial
	begin
		logic [15:0] w;
		rst = 1'b1;
		refuse = '0;
		// Negative temperatures and a saturating light word
		words = '{16'h1980, 16'hf480, 16'h8000, 16'h7f00,
			16'h3fa0, 16'hffff, 16'hf001, 16'ha800};
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		check_reset_state();
		for (int s = 0; s < NUM_SWEEPS; s++)
		begin
			do
				@(posedge clk);
			while (!sweep_done);
			if (s + 1 < NUM_SWEEPS)
			begin
				for (int i = 0; i < NUM_SENSORS; i++)
				begin
					random_word(w);
					words[i] <= w;
				end
				refuse <= (s == 0) ? REFUSE_EAST_GEO : '0; // Second sweep only
			end
		end
		repeat (2) @(posedge clk); // Let the last comparison finish
		assert (sweeps_seen == NUM_SWEEPS)
		else
		begin
			errors++;
			$display("Saw %0d sweeps instead of %0d", sweeps_seen, NUM_SWEEPS);
		end
		$display("Sweeps: %0d, errors: %0d", sweeps_seen, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	initial
	begin
		int cycles;
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: sweeps did not finish within %0d cycles, %0d errors so far",
			TIMEOUT_CYCLES, errors);
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* bench/sensor_hub_sva.sv */
`timescale 1ns/1ns
`default_nettype none

module sensor_hub_sva (
	input logic clk,
	input logic rst,
	input logic start,
	input logic ready,
	input logic ack,
	input logic write,
	input logic scl_low,
	input logic sda,
	input logic sda_may_toggle // START or STOP being generated
);

	start_needs_ready: assert property (@(posedge clk) disable iff (rst) start |-> ready)
		else $error("start pulsed while the engine was busy");

	sda_stable_scl_high: assert property (@(posedge clk) disable iff (rst)
		$changed(sda) && !scl_low |-> sda_may_toggle)
		else $error("SDA moved while SCL was high outside START or STOP");

	// One bank write per finished read, right after ready rises
	write_needs_ack: assert property (@(posedge clk) disable iff (rst)
		write |-> ack && $rose(ready))
		else $error("bank write without a freshly finished acknowledged read");

endmodule

bind i2c_read_engine sensor_hub_sva i_engine_sva (
	.clk(clk),
	.rst(rst),
	.start(bus.start),
	.ready(bus.ready),
	.ack(bus.ack),
	.write(1'b0),
	.scl_low(scl_drive_low),
	.sda(sda_line),
	.sda_may_toggle(state == ST_START || state == ST_STOP)
);

bind sensor_poll_ctrl sensor_hub_sva i_ctrl_sva (
	.clk(clk),
	.rst(rst),
	.start(bus.start),
	.ready(bus.ready),
	.ack(bus.ack),
	.write(write),
	.scl_low(1'b1),
	.sda(1'b1),
	.sda_may_toggle(1'b1)
);

`default_nettype wire

/* bench/i2c_sensor_model.sv */
`timescale 1ns/1ns
`default_nettype none

module i2c_sensor_model
	import sensor_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic scl,
	input logic sda,
	input logic [15:0] words [NUM_SENSORS], // Reply per sensor, poll order
	input logic [NUM_SENSORS-1:0] refuse, // No acknowledge for these sensors
	output logic sda_drive_low,
	output logic addr_valid, // One pulse per received address byte
	output logic [7:0] addr_byte
);

	logic scl_q;
	logic sda_q;
	logic active; // Between START and STOP
	logic acked;
	int fall_cnt; // SCL falls since START
	logic [7:0] shift;
	logic [15:0] reply; // MSB goes out next

	always @(posedge clk)
	begin
		logic hit;
		sensor_idx_t sel;
		hit = 1'b0;
		sel = '0;
		for (int i = 0; i < NUM_SENSORS; i++)
		begin
			if (SENSOR_ADDR[i] == shift[6:0])
			begin
				hit = 1'b1;
				sel = sensor_idx_t'(i);
			end
		end
		if (rst)
		begin
			scl_q <= 1'b1;
			sda_q <= 1'b1;
			active <= 1'b0;
			acked <= 1'b0;
			fall_cnt <= 0;
			sda_drive_low <= 1'b0;
			addr_valid <= 1'b0;
		end
		else
		begin
			scl_q <= scl;
			sda_q <= sda;
			addr_valid <= 1'b0;
			if (scl && scl_q && sda_q && !sda)
			begin
				active <= 1'b1; // START
				acked <= 1'b0;
				fall_cnt <= 0;
				shift <= 8'h00;
			end
			else if (scl && scl_q && !sda_q && sda)
			begin
				active <= 1'b0; // STOP
				sda_drive_low <= 1'b0;
			end
			else if (active && scl && !scl_q && fall_cnt >= 1 && fall_cnt <= 8)
			begin
				shift <= {shift[6:0], sda};
				if (fall_cnt == 8)
				begin
					// Address is in shift[6:0], read bit still on the line
					addr_valid <= 1'b1;
					addr_byte <= {shift[6:0], sda};
					acked <= sda && hit && !refuse[sel];
					reply <= words[sel];
				end
			end
			else if (active && !scl && scl_q)
			begin
				fall_cnt <= fall_cnt + 1;
				if (acked && fall_cnt == 8)
					sda_drive_low <= 1'b1; // Address acknowledge
				else if (acked && ((fall_cnt >= 9 && fall_cnt <= 16) ||
					(fall_cnt >= 18 && fall_cnt <= 25)))
				begin
					sda_drive_low <= !reply[15];
					reply <= {reply[14:0], 1'b0};
				end
				else
					sda_drive_low <= 1'b0; // Master acknowledge slots
			end
		end
	end

endmodule

`default_nettype wire

/* design/sensor_hub.sv */
`timescale 1ns/1ns
`default_nettype none

module sensor_hub
	import sensor_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic sda_line,
	output logic scl_drive_low,
	output logic sda_drive_low,
	output logic sweep_done,
	output logic signed [7:0] solar_celsius,
	output logic signed [7:0] greenhouse_celsius,
	output logic signed [7:0] ambient_celsius,
	output logic signed [7:0] geothermal_celsius,
	output logic [15:0] n_lux,
	output logic [15:0] e_lux,
	output logic [15:0] s_lux,
	output logic [15:0] w_lux
);

	i2c_req_if req ();

	logic write;
	sensor_idx_t index;
	logic [15:0] word;
	raw_reading_u reading_for_lux;
	logic [15:0] lux;
	logic signed [7:0] celsius [4];
	logic [15:0] lux_out [4];

	i2c_read_engine i_engine (
		.clk(clk),
		.rst(rst),
		.bus(req),
		.sda_line(sda_line),
		.scl_drive_low(scl_drive_low),
		.sda_drive_low(sda_drive_low)
	);

	sensor_poll_ctrl i_ctrl (
		.clk(clk),
		.rst(rst),
		.bus(req),
		.write(write),
		.index(index),
		.word(word),
		.sweep_done(sweep_done)
	);

	lux_convert i_lux (
		.reading(reading_for_lux),
		.lux(lux)
	);

	reading_bank i_bank (
		.clk(clk),
		.rst(rst),
		.write(write),
		.index(index),
		.word(word),
		.lux(lux),
		.reading_for_lux(reading_for_lux),
		.celsius(celsius),
		.lux_out(lux_out)
	);

	assign solar_celsius = celsius[0];
	assign greenhouse_celsius = celsius[1];
	assign ambient_celsius = celsius[2];
	assign geothermal_celsius = celsius[3];
	assign n_lux = lux_out[0];
	assign e_lux = lux_out[1];
	assign s_lux = lux_out[2];
	assign w_lux = lux_out[3];

endmodule

`default_nettype wire

/* design/reading_bank.sv */
`timescale 1ns/1ns
`default_nettype none

module reading_bank
	import sensor_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic write,
	input sensor_idx_t index,
	input raw_reading_u word,
	input logic [15:0] lux,
	output raw_reading_u reading_for_lux,
	output logic signed [7:0] celsius [4],
	output logic [15:0] lux_out [4]
);

	logic is_light; // Upper half of the poll order

	assign is_light = index[2];
	assign reading_for_lux = word; // Converted beside the bank

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < 4; i++)
			begin
				celsius[i] <= 8'sd0;
				lux_out[i] <= 16'd0;
			end
		end
		else if (write)
		begin
			if (is_light)
				lux_out[index[1:0]] <= lux;
			else
				celsius[index[1:0]] <= word.temp.whole; // Fraction dropped
		end
	end

endmodule

`default_nettype wire

/* design/lux_convert.sv */
`timescale 1ns/1ns
`default_nettype none

module lux_convert
	import sensor_pkg::*;
(
	input raw_reading_u reading,
	output logic [15:0] lux
);

	logic [26:0] scaled; // Fraction shifted by up to 15
	logic [26:0] whole;

	// Scale first and divide last to keep the low bits
	assign scaled = 27'(reading.light.fraction) << reading.light.exponent;
	assign whole = scaled / 27'd100;
	assign lux = |whole[26:16] ? 16'hffff : whole[15:0]; // Saturate

endmodule

`default_nettype wire

/* design/sensor_poll_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module sensor_poll_ctrl
	import sensor_pkg::*;
(
	input logic clk,
	input logic rst,
	i2c_req_if.ctrl bus,
	output logic write,
	output sensor_idx_t index,
	output logic [15:0] word,
	output logic sweep_done
);

	logic waiting; // Low only until the first read is issued
	logic done; // Engine finished the current sensor

	// Ready is still high in the cycle after start, so ignore that cycle
	assign done = waiting && bus.ready && !bus.start;
	assign write = done && bus.ack;
	assign word = bus.data;
	assign bus.addr = SENSOR_ADDR[index];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			waiting <= 1'b0;
			index <= '0;
			bus.start <= 1'b0;
			sweep_done <= 1'b0;
		end
		else
		begin
			bus.start <= 1'b0;
			sweep_done <= 1'b0;
			if (!waiting && bus.ready)
			begin
				bus.start <= 1'b1; // Solar first
				waiting <= 1'b1;
			end
			else if (done)
			begin
				bus.start <= 1'b1; // Next sensor, even after a NACK
				index <= index + 1'b1; // Wraps 7 to 0
				sweep_done <= index == sensor_idx_t'(NUM_SENSORS - 1);
			end
		end
	end

endmodule

`default_nettype wire

/* design/i2c_read_engine.sv */
`timescale 1ns/1ns
`default_nettype none

module i2c_read_engine
	import sensor_pkg::*;
(
	input logic clk,
	input logic rst,
	i2c_req_if.engine bus,
	input logic sda_line,
	output logic scl_drive_low,
	output logic sda_drive_low
);

	enum logic [2:0] {
		ST_IDLE,
		ST_START,
		ST_ADDR,
		ST_ADDR_ACK,
		ST_READ,
		ST_MACK,
		ST_STOP
	} state;

	logic [QUARTER_W-1:0] div_cnt; // Clocks within a quarter
	logic [1:0] quarter; // Quarter within a bit
	logic [2:0] bit_cnt;
	logic second_byte;
	logic [7:0] addr_shift; // Address and read bit from the MSB
	logic tick;

	assign tick = div_cnt == QUARTER_LAST;

	// SCL is low in quarters 0 and 1 while SDA moves in quarter 1 and is sampled after quarter 2
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= ST_IDLE;
			div_cnt <= '0;
			quarter <= 2'd0;
			bit_cnt <= 3'd0;
			second_byte <= 1'b0;
			bus.ready <= 1'b1;
			bus.ack <= 1'b0;
			scl_drive_low <= 1'b0;
			sda_drive_low <= 1'b0;
		end
		else if (state == ST_IDLE)
		begin
			div_cnt <= '0;
			quarter <= 2'd0;
			if (bus.start)
			begin
				state <= ST_START;
				bus.ready <= 1'b0;
				bus.ack <= 1'b0;
				addr_shift <= {bus.addr, 1'b1}; // Read bit
				bit_cnt <= 3'd0;
				second_byte <= 1'b0;
			end
		end
		else
		begin
			div_cnt <= tick ? '0 : div_cnt + 1'b1;
			if (tick)
			begin
				quarter <= quarter + 2'd1;
				case (quarter)
					2'd0:
					begin
						case (state)
							ST_ADDR: sda_drive_low <= !addr_shift[7];
							ST_ADDR_ACK, ST_READ: sda_drive_low <= 1'b0; // Slave drives
							ST_MACK: sda_drive_low <= !second_byte; // NACK on last byte
							ST_STOP: sda_drive_low <= 1'b1;
							default: ;
						endcase
					end
					2'd1:
					begin
						if (state == ST_START)
							sda_drive_low <= 1'b1; // START with SCL high
						else
							scl_drive_low <= 1'b0;
					end
					2'd2:
					begin
						case (state)
							ST_ADDR_ACK: bus.ack <= !sda_line;
							ST_READ: bus.data <= {bus.data[14:0], sda_line};
							ST_STOP: sda_drive_low <= 1'b0; // STOP with SCL high
							default: ;
						endcase
					end
					default:
					begin
						scl_drive_low <= state != ST_STOP;
						bit_cnt <= bit_cnt + 3'd1;
						case (state)
							ST_START:
							begin
								state <= ST_ADDR;
								bit_cnt <= 3'd0;
							end
							ST_ADDR:
							begin
								addr_shift <= {addr_shift[6:0], 1'b0};
								if (bit_cnt == 3'd7)
									state <= ST_ADDR_ACK;
							end
							ST_ADDR_ACK:
							begin
								state <= bus.ack ? ST_READ : ST_STOP; // Give up at once on NACK
								bit_cnt <= 3'd0;
							end
							ST_READ:
							begin
								if (bit_cnt == 3'd7)
									state <= ST_MACK;
							end
							ST_MACK:
							begin
								state <= second_byte ? ST_STOP : ST_READ;
								second_byte <= 1'b1;
								bit_cnt <= 3'd0; // Full eight bits for the second byte
							end
							default:
							begin
								state <= ST_IDLE;
								bus.ready <= 1'b1; // Result valid from here
							end
						endcase
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* design/i2c_req_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface i2c_req_if;

	logic start; // One-cycle strobe, only while ready
	logic [6:0] addr;
	logic ready; // High when idle and result valid
	logic ack; // Address was acknowledged
	logic [15:0] data; // First byte in upper half

	modport ctrl (output start, output addr, input ready, input ack, input data);
	modport engine (input start, input addr, output ready, output ack, output data);

endinterface

`default_nettype wire

/* design/sensor_pkg.sv */
`default_nettype none

package sensor_pkg;

	localparam int I2C_QUARTER = 4; // System clocks per quarter SCL period
	localparam int QUARTER_W = $clog2(I2C_QUARTER);
	localparam logic [QUARTER_W-1:0] QUARTER_LAST = QUARTER_W'(I2C_QUARTER - 1);

	localparam int NUM_SENSORS = 8;

	// Poll order, temperature sensors first
	localparam logic [6:0] SENSOR_ADDR [NUM_SENSORS] = '{
		7'b1001000, // Solar
		7'b1001001, // Greenhouse
		7'b1001010, // Ambient
		7'b1001011, // Geothermal
		7'b1000100, // North
		7'b1000101, // East
		7'b1000110, // South
		7'b1000111  // West
	};

	typedef logic [2:0] sensor_idx_t; // 0-3 temperature, 4-7 light

	typedef union packed {
		struct packed {
			logic signed [7:0] whole; // Whole degrees
			logic [7:0] frac;
		} temp;
		struct packed {
			logic [3:0] exponent;
			logic [11:0] fraction;
		} light;
	} raw_reading_u;

endpackage

`default_nettype wire
